/* src.f */
common/mio_pkg.sv
rx/mio_rx_deser.sv
rx/mio_rx_fifo.sv
rx/mio_if.sv
rtl/mio_cfg.sv
rtl/mio_rx_top.sv
bench/tb_mio_rx.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the receive path testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_mio_rx -o sim_tb_mio_rx

# the log decides the outcome
./obj_dir/sim_tb_mio_rx > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
   exit 1
fi
exit 0

/* bench/tb_mio_rx.sv */
module tb_mio_rx import mio_pkg::*; ();

   localparam int mpw    = 128;         // dut defaults
   localparam int iow    = 8;
   localparam int depth  = 4;
   localparam int nbeats = mpw / iow;

   // run limit follows the words per test
   localparam int n_mesh      = 6;
   localparam int n_auto      = 4 * 2;  // four datasizes with two words each
   localparam int n_msb       = 5;
   localparam int n_bp        = depth + 2;
   localparam int total_beats = (n_mesh + n_auto + n_msb + n_bp) * nbeats;
   localparam int max_cycles  = 4 * total_beats + 200;

   logic           clk;
   logic           reset;
   logic           io_valid;
   logic [iow-1:0] io_data;
   logic           io_wait;
   logic           access_out;
   logic [pw-1:0]  packet_out;
   logic           wait_in;
   logic           cfg_req;
   logic           cfg_write;
   logic           cfg_addr;
   logic [31:0]    cfg_wdata;
   logic           cfg_ack;
   logic [31:0]    cfg_rdata;

   logic [31:0]    lfsr_state = 32'ha5a8698f;
   logic [pw-1:0]  exp_q [$];           // expected transactions in arrival order
   logic [pw-1:0]  held_pkt;            // packet seen under wait_in
   logic           held = 1'b0;
   int             cycles = 0;

   // shadow of the config registers
   logic           cur_amode;
   logic           cur_lsb;
   logic [4:0]     cur_ctrl;
   logic [3:0]     cur_ds;
   logic [31:0]    cur_dst;

   mio_rx_top dut0 (
      .clk, .reset, .io_valid, .io_data, .io_wait,
      .access_out, .packet_out, .wait_in,
      .cfg_req, .cfg_write, .cfg_addr, .cfg_wdata, .cfg_ack, .cfg_rdata
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;           // period 100
   end

   //##########################################################################
   // helpers
   //##########################################################################
   // x^32 + x^22 + x^2 + x + 1 with one new bit per call
   function automatic logic lfsr_step();
      logic fb;
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [mpw-1:0] rand_bits(input int n);
      logic [mpw-1:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[mpw-2:0], lfsr_step()};
      end
      return r;
   endfunction

   task automatic check_eq(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
      if (got !== exp) begin
         $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // transaction the core should see for one link word
   function automatic logic [pw-1:0] expect_packet(input logic [mpw-1:0] w);
      logic [1:0] dm;
      if (!cur_amode) begin
         return w[pw-1:0];              // mesh mode passes the low bits
      end
      case (cur_ds)
         4'd1:    dm = 2'd0;
         4'd2:    dm = 2'd1;
         4'd4:    dm = 2'd2;
         default: dm = 2'd3;
      endcase
      // srcaddr, data, dstaddr, ctrlmode, datamode, write
      return {w[63:32], w[31:0], cur_dst, cur_ctrl, dm, 1'b1};
   endfunction

   //##########################################################################
   // bus drivers enter and leave just after a rising edge
   //##########################################################################
   task automatic cfg_access(input logic wr, input logic addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      cfg_req   = 1'b1;
      cfg_write = wr;
      cfg_addr  = addr;
      cfg_wdata = wdata;
      @(posedge clk);
      @(negedge clk);
      check_eq("cfg_ack", 128'(cfg_ack), 128'(1'b1));    // one edge after req
      rdata = cfg_rdata;
      @(posedge clk);
      #10;
      cfg_req = 1'b0;
      @(posedge clk);
      @(negedge clk);
      check_eq("cfg_ack", 128'(cfg_ack), 128'(1'b0));    // one edge after release
      @(posedge clk);
      #10;
   endtask

   task automatic cfg_read_check(input logic addr, input logic [31:0] exp);
      logic [31:0] rd;
      cfg_access(1'b0, addr, 32'd0, rd);
      check_eq("cfg_rdata", 128'(rd), 128'(exp));
   endtask

   task automatic set_mode(input logic am, input logic lsb, input logic [4:0] ctrl,
                           input logic [3:0] ds);
      logic [31:0] unused_rd;
      cur_amode = am;
      cur_lsb   = lsb;
      cur_ctrl  = ctrl;
      cur_ds    = ds;
      cfg_access(1'b1, cfg_addr_mode, {21'd0, ds, ctrl, lsb, am}, unused_rd);
   endtask

   task automatic set_dst(input logic [31:0] dst);
      logic [31:0] unused_rd;
      cur_dst = dst;
      cfg_access(1'b1, cfg_addr_dst, dst, unused_rd);
   endtask

   // one word as beats with retries while io_wait stalls the link
   task automatic send_word(input logic [mpw-1:0] w);
      int   i;
      logic taken;
      i = 0;
      while (i < nbeats) begin
         io_valid = 1'b1;
         io_data  = cur_lsb ? w[i*iow +: iow] : w[mpw-1-i*iow -: iow];
         @(negedge clk);
         taken = !io_wait;              // stable until the next edge
         @(posedge clk);
         #10;
         if (taken) begin
            i++;
         end
      end
      io_valid = 1'b0;
   endtask

   task automatic send_stream(input int n);
      logic [mpw-1:0] w;
      for (int k = 0; k < n; k++) begin
         w = rand_bits(mpw);
         exp_q.push_back(expect_packet(w));
         send_word(w);
      end
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0 || access_out) begin
         @(posedge clk);
         #10;
      end
   endtask

   //##########################################################################
   // directed tests
   //##########################################################################
   task automatic test_reset_state();
      check_eq("access_out", 128'(access_out), 128'(1'b0));
      check_eq("io_wait", 128'(io_wait), 128'(1'b0));
      check_eq("cfg_ack", 128'(cfg_ack), 128'(1'b0));
      cfg_read_check(cfg_addr_mode, 32'd0);
      cfg_read_check(cfg_addr_dst, 32'd0);
   endtask

   task automatic test_cfg_access();
      logic [31:0] w_mode;
      logic [31:0] w_dst;
      logic [31:0] unused_rd;
      w_mode = 32'(rand_bits(32));
      w_dst  = 32'(rand_bits(32));
      cfg_access(1'b1, cfg_addr_mode, w_mode, unused_rd);
      cfg_access(1'b1, cfg_addr_dst, w_dst, unused_rd);
      cfg_read_check(cfg_addr_mode, w_mode & 32'h0000_07ff);   // 11 bits implemented
      cfg_read_check(cfg_addr_dst, w_dst);
   endtask

   task automatic test_mesh_lsb_first();
      set_mode(1'b0, 1'b1, 5'd0, 4'd0);
      send_stream(n_mesh);
      wait_drain();
   endtask

   task automatic test_auto_address();
      logic [3:0] sizes [4];
      sizes = '{4'd1, 4'd2, 4'd4, 4'd7};  // one per datamode code
      foreach (sizes[s]) begin
         set_dst(32'(rand_bits(32)));
         set_mode(1'b1, 1'b1, 5'(rand_bits(5)), sizes[s]);
         send_stream(n_auto / 4);
         wait_drain();
      end
   endtask

   task automatic test_msb_first();
      set_mode(1'b0, 1'b0, 5'd0, 4'd0);
      send_stream(n_msb);
      wait_drain();
   endtask

   task automatic test_back_pressure();
      set_mode(1'b0, 1'b1, 5'd0, 4'd0);
      wait_in = 1'b1;
      send_stream(n_bp);                // output reg, fifo, then one held word
      check_eq("io_wait", 128'(io_wait), 128'(1'b1));
      check_eq("access_out", 128'(access_out), 128'(1'b1));
      wait_in = 1'b0;
      wait_drain();
      check_eq("io_wait", 128'(io_wait), 128'(1'b0));
   endtask

   //##########################################################################
   // monitor and run limit
   //##########################################################################
   always @(negedge clk) begin
      if (!reset) begin
         if (held) begin
            check_eq("access_out", 128'(access_out), 128'(1'b1));
            check_eq("packet_out", 128'(packet_out), 128'(held_pkt));
         end
         held     = access_out && wait_in;
         held_pkt = packet_out;
         if (access_out && !wait_in) begin       // consumed on next edge
            if (exp_q.size() == 0) begin
               $display("transaction at %0t with nothing expected", $time);
               $display("RESULT: FAIL");
               $fatal(1, "unexpected transaction");
            end else begin
               check_eq("packet_out", 128'(packet_out), 128'(exp_q.pop_front()));
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > max_cycles) begin
         $display("run stopped after %0d cycles without finishing", cycles);
         $display("RESULT: FAIL");
         $fatal(1, "timeout");
      end
   end

   initial begin
      reset     = 1'b1;
      io_valid  = 1'b0;
      io_data   = '0;
      wait_in   = 1'b0;
      cfg_req   = 1'b0;
      cfg_write = 1'b0;
      cfg_addr  = 1'b0;
      cfg_wdata = '0;
      cur_amode = 1'b0;
      cur_lsb   = 1'b0;
      cur_ctrl  = '0;
      cur_ds    = '0;
      cur_dst   = '0;
      repeat (8) @(posedge clk);
      #10;
      reset = 1'b0;
      test_reset_state();
      test_cfg_access();
      test_mesh_lsb_first();
      test_auto_address();
      test_msb_first();
      test_back_pressure();
      $display("RESULT: PASS");
      $finish;
   end

endmodule

/* rtl/mio_rx_top.sv */
module mio_rx_top import mio_pkg::*; #(
   parameter int mpw   = 128,           // link word width
   parameter int iow   = 8,             // beat width
   parameter int depth = 4              // fifo words
) (
   input  logic           clk,
   input  logic           reset,
   // link
   input  logic           io_valid,
   input  logic [iow-1:0] io_data,
   output logic           io_wait,
   // core
   output logic           access_out,
   output logic [pw-1:0]  packet_out,
   input  logic           wait_in,
   // config port
   input  logic           cfg_req,
   input  logic           cfg_write,
   input  logic           cfg_addr,
   input  logic [31:0]    cfg_wdata,
   output logic           cfg_ack,
   output logic [31:0]    cfg_rdata
);

   logic                  amode;
   logic                  lsbfirst;
   logic [ctrlmode_w-1:0] ctrlmode;
   logic [3:0]            datasize;
   logic [aw-1:0]         dstaddr;
   logic                  push;        // deser to fifo
   logic [mpw-1:0]        push_data;
   logic                  full;
   logic                  rx_access;   // fifo to translator
   logic [mpw-1:0]        head;
   logic                  rx_wait;

   //##########################################################################
   // config, then beats to words to transactions
   //##########################################################################
   mio_cfg cfg0 (
      .clk, .reset, .cfg_req, .cfg_write, .cfg_addr, .cfg_wdata, .cfg_ack, .cfg_rdata,
      .amode, .lsbfirst, .ctrlmode, .datasize, .dstaddr
   );

   mio_rx_deser #(.mpw(mpw), .iow(iow)) deser0 (
      .clk, .reset, .lsbfirst, .io_valid, .io_data, .io_wait,
      .push, .push_data, .full
   );

   mio_rx_fifo #(.mpw(mpw), .depth(depth)) fifo0 (
      .clk, .reset, .push, .push_data, .full,
      .pop       (rx_access & ~rx_wait),  // same pop rule as mio_if
      .rx_access, .head
   );

   mio_if #(.mpw(mpw)) if0 (
      .clk, .reset, .amode, .ctrlmode, .datasize, .dstaddr,
      .rx_access_in (rx_access),
      .rx_packet_in (head),
      .rx_wait_out  (rx_wait),
      .access_out, .packet_out, .wait_in
   );

endmodule

/* rtl/mio_cfg.sv */
module mio_cfg import mio_pkg::*; (
   input  logic                  clk,
   input  logic                  reset,
   // four-phase host port
   input  logic                  cfg_req,
   input  logic                  cfg_write,
   input  logic                  cfg_addr,
   input  logic [31:0]           cfg_wdata,
   output logic                  cfg_ack,
   output logic [31:0]           cfg_rdata,
   // decoded config
   output logic                  amode,
   output logic                  lsbfirst,
   output logic [ctrlmode_w-1:0] ctrlmode,
   output logic [3:0]            datasize,
   output logic [aw-1:0]         dstaddr
);

   logic [10:0] mode_reg;               // datasize, ctrlmode, lsbfirst, amode
   logic        start;                  // fresh request seen
   logic [31:0] rd_mux;

   //##########################################################################
   // handshake
   //##########################################################################
   assign start = cfg_req & ~cfg_ack;   // ack low means a new request

   always_ff @(posedge clk) begin
      if (reset) begin
         cfg_ack <= 1'b0;
      end else if (start) begin
         cfg_ack <= 1'b1;
      end else if (~cfg_req) begin
         cfg_ack <= 1'b0;               // host released, finish the cycle
      end
   end

   //##########################################################################
   // registers
   //##########################################################################
   always_ff @(posedge clk) begin
      if (reset) begin
         mode_reg <= '0;
         dstaddr  <= '0;
      end else if (start & cfg_write) begin
         if (cfg_addr == cfg_addr_mode) begin
            mode_reg <= cfg_wdata[10:0];
         end else begin
            dstaddr <= cfg_wdata;
         end
      end
   end

   assign rd_mux = (cfg_addr == cfg_addr_dst) ? dstaddr : {21'd0, mode_reg};

   // captured with the ack so it holds after the host drops req
   always_ff @(posedge clk) begin
      if (start) begin
         cfg_rdata <= rd_mux;
      end
   end

   assign amode    = mode_reg[0];
   assign lsbfirst = mode_reg[1];
   assign ctrlmode = mode_reg[6:2];
   assign datasize = mode_reg[10:7];

   // ack answers a request, never raised on its own
   a_ack_needs_req : assert property (
      @(posedge clk) disable iff (reset)
      $rose(cfg_ack) |-> $past(cfg_req)
   ) else $error("cfg_ack rose without cfg_req");

endmodule

/* rx/mio_if.sv */
module mio_if import mio_pkg::*; #(
   parameter int mpw = 128              // link word width, at least pw
) (
   input  logic                  clk,
   input  logic                  reset,
   // config
   input  logic                  amode,     // auto address mode
   input  logic [ctrlmode_w-1:0] ctrlmode,
   input  logic [3:0]            datasize,  // bytes per access
   input  logic [aw-1:0]         dstaddr,
   // from rx fifo
   input  logic                  rx_access_in,
   input  logic [mpw-1:0]        rx_packet_in,
   output logic                  rx_wait_out,
   // to core
   output logic                  access_out,
   output logic [pw-1:0]         packet_out,
   input  logic                  wait_in
);

   mesh_t rx_fields;                    // fields of incoming word
   mesh_t tx_fields;                    // fields after translation
   logic  load;                         // output register free this edge
   logic  pop;

   //##########################################################################
   // translation
   //##########################################################################
   always_comb begin
      rx_fields = mesh_unpack(rx_packet_in[pw-1:0]);
      tx_fields = rx_fields;            // mesh mode passes through
      if (amode) begin
         // raw streaming data, build transaction around it
         tx_fields.write    = 1'b1;
         tx_fields.datamode = datasize_to_datamode(datasize);
         tx_fields.ctrlmode = ctrlmode;
         tx_fields.dstaddr  = dstaddr;
         tx_fields.data     = rx_packet_in[31:0];
         tx_fields.srcaddr  = rx_packet_in[63:32];
      end
   end

   //##########################################################################
   // one-entry output register
   //##########################################################################
   assign load        = ~access_out | ~wait_in;  // empty or being consumed
   assign rx_wait_out = ~load;
   assign pop         = rx_access_in & load;

   always_ff @(posedge clk) begin
      if (reset) begin
         access_out <= 1'b0;
      end else if (load) begin
         access_out <= rx_access_in;
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         packet_out <= mesh_pack(tx_fields);  // no reset on payload
      end
   end

   // core sees a steady transaction while it stalls
   a_hold_under_wait : assert property (
      @(posedge clk) disable iff (reset)
      (access_out && wait_in) |=> (access_out && $stable(packet_out))
   ) else $error("packet_out changed under wait_in");

endmodule

/* rx/mio_rx_fifo.sv */
module mio_rx_fifo #(
   parameter int mpw   = 128,           // link word width
   parameter int depth = 4              // number of words
) (
   input  logic           clk,
   input  logic           reset,
   // write side
   input  logic           push,
   input  logic [mpw-1:0] push_data,
   output logic           full,
   // read side, show-ahead
   input  logic           pop,
   output logic           rx_access,    // not empty
   output logic [mpw-1:0] head
);

   localparam int ptrw = (depth > 1) ? $clog2(depth) : 1;
   localparam int cntw = $clog2(depth + 1);

   logic [mpw-1:0]  mem [depth];        // word storage
   logic [ptrw-1:0] wr_ptr;
   logic [ptrw-1:0] rd_ptr;
   logic [cntw-1:0] count;              // words held

   //##########################################################################
   // storage
   //##########################################################################
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   assign head      = mem[rd_ptr];      // head always on the output
   assign full      = (count == cntw'(depth));
   assign rx_access = (count != '0);

   //##########################################################################
   // pointers and occupancy
   //##########################################################################
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            // wrap explicitly, depth need not be a power of two
            wr_ptr <= (wr_ptr == ptrw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == ptrw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else begin
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;    // idle or simultaneous
         endcase
      end
   end

   // deserializer must respect full
   a_no_push_full : assert property (
      @(posedge clk) disable iff (reset)
      push |-> !full
   ) else $error("push into full fifo");

   // translator must respect empty
   a_no_pop_empty : assert property (
      @(posedge clk) disable iff (reset)
      pop |-> rx_access
   ) else $error("pop from empty fifo");

endmodule

/* rx/mio_rx_deser.sv */
module mio_rx_deser #(
   parameter int mpw = 128,             // link word width
   parameter int iow = 8                // beat width
) (
   input  logic           clk,
   input  logic           reset,
   input  logic           lsbfirst,     // first beat lands in low bits
   // link side
   input  logic           io_valid,
   input  logic [iow-1:0] io_data,
   output logic           io_wait,
   // fifo side
   output logic           push,
   output logic [mpw-1:0] push_data,
   input  logic           full
);

   localparam int nbeats = mpw / iow;
   localparam int cw     = (nbeats > 1) ? $clog2(nbeats) : 1;

   logic [cw-1:0]  cnt;                 // beats taken in current word
   logic [mpw-1:0] sreg;                // partial word or the full word while held
   logic [mpw-1:0] sreg_next;           // sreg with current beat shifted in
   logic           hold;                // finished word stuck behind full fifo
   logic           take;                // beat accepted this edge
   logic           last;                // accepted beat closes the word

   //##########################################################################
   // beat acceptance
   //##########################################################################
   assign io_wait = hold;               // stall link only while a word waits
   assign take    = io_valid & ~io_wait;
   assign last    = take & (cnt == cw'(nbeats - 1));

   // lsb first shifts down so beat 0 ends at the bottom
   // msb first shifts up so beat 0 ends at the top
   always_comb begin
      if (lsbfirst) begin
         sreg_next = {io_data, sreg[mpw-1:iow]};
      end else begin
         sreg_next = {sreg[mpw-iow-1:0], io_data};
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         sreg <= sreg_next;             // shift in the accepted beat
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         cnt <= '0;
      end else if (last) begin
         cnt <= '0;                     // wrap for next word
      end else if (take) begin
         cnt <= cnt + 1'b1;
      end
   end

   //##########################################################################
   // hand-off to fifo
   //##########################################################################
   // fresh word goes straight through and a held word comes from sreg
   assign push      = (last | hold) & ~full;
   assign push_data = hold ? sreg : sreg_next;

   always_ff @(posedge clk) begin
      if (reset) begin
         hold <= 1'b0;
      end else if (last & full) begin
         hold <= 1'b1;                  // park until space frees up
      end else if (hold & ~full) begin
         hold <= 1'b0;                  // pushed this edge
      end
   end

   // a held word means the next word has not started yet
   a_no_beat_while_held : assert property (
      @(posedge clk) disable iff (reset)
      io_wait |-> (cnt == '0)
   ) else $error("beat accepted while word held");

endmodule

/* common/mio_pkg.sv */
package mio_pkg;

   //##########################################################################
   // mesh transaction geometry
   //##########################################################################
   localparam int aw = 32;              // address and data width
   localparam int pw = 104;             // mesh packet width

   localparam int write_bit    = 0;
   localparam int datamode_lsb = 1;
   localparam int datamode_w   = 2;
   localparam int ctrlmode_lsb = 3;
   localparam int ctrlmode_w   = 5;
   localparam int dstaddr_lsb  = 8;
   localparam int data_lsb     = 40;
   localparam int srcaddr_lsb  = 72;

   // datamode codes, size of one access
   localparam logic [datamode_w-1:0] dm_byte   = 2'd0;
   localparam logic [datamode_w-1:0] dm_half   = 2'd1;
   localparam logic [datamode_w-1:0] dm_word   = 2'd2;
   localparam logic [datamode_w-1:0] dm_double = 2'd3;

   // config register map, one address bit
   localparam logic cfg_addr_mode = 1'b0; // amode, lsbfirst, ctrlmode, datasize
   localparam logic cfg_addr_dst  = 1'b1; // dstaddr for amode

   // unpacked view of a mesh packet
   typedef struct packed {
      logic [aw-1:0]         srcaddr;
      logic [aw-1:0]         data;
      logic [aw-1:0]         dstaddr;
      logic [ctrlmode_w-1:0] ctrlmode;
      logic [datamode_w-1:0] datamode;
      logic                  write;
   } mesh_t;

   // byte count to datamode, odd sizes fall back to double
   function automatic logic [datamode_w-1:0] datasize_to_datamode(input logic [3:0] datasize);
      case (datasize)
         4'd1:    return dm_byte;
         4'd2:    return dm_half;
         4'd4:    return dm_word;
         default: return dm_double;
      endcase
   endfunction

   function automatic logic [pw-1:0] mesh_pack(input mesh_t m);
      logic [pw-1:0] p;
      p                              = '0;
      p[write_bit]                   = m.write;
      p[datamode_lsb +: datamode_w]  = m.datamode;
      p[ctrlmode_lsb +: ctrlmode_w]  = m.ctrlmode;
      p[dstaddr_lsb +: aw]           = m.dstaddr;
      p[data_lsb +: aw]              = m.data;
      p[srcaddr_lsb +: aw]           = m.srcaddr;
      return p;
   endfunction

   function automatic mesh_t mesh_unpack(input logic [pw-1:0] p);
      mesh_t m;
      m.write    = p[write_bit];
      m.datamode = p[datamode_lsb +: datamode_w];
      m.ctrlmode = p[ctrlmode_lsb +: ctrlmode_w];
      m.dstaddr  = p[dstaddr_lsb +: aw];
      m.data     = p[data_lsb +: aw];
      m.srcaddr  = p[srcaddr_lsb +: aw];
      return m;
   endfunction

endpackage
